//--- vlog.f
+incdir+include
logic/ps2_pkg.sv
logic/ps2_line_timer.sv
logic/ps2_frame_shifter.sv
logic/ps2_device_fsm.sv
logic/ps2_device.sv
tb/tb_ps2_device.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the PS/2 device testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

if ! verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
	--top-module tb_ps2_device -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/Vtb_ps2_device)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Test passed" <<< "$sim_output"; then
	exit 0
fi
exit 1

//--- include/ps2_host_tasks.svh
`ifndef PS2_HOST_TASKS_SVH
`define PS2_HOST_TASKS_SVH

//////////////////////////////
// Host side of the bus
//////////////////////////////

// Waits for the wired clock line to reach a level
task automatic host_wait_clock(input logic level, input bit report, input string what,
	output bit seen);
	int count;
	seen = 1'b0;
	count = 0;
	while (!seen && count < ps2_pkg::HOST_TIMEOUT_CYCLES)
	begin
		@(posedge clk);
		if (ps2_clock === level)
			seen = 1'b1;
		count++;
	end
	if (!seen && report)
	begin
		$display("[ERROR] host gave up waiting for %s", what);
		error_count++;
	end
endtask

// Request-to-send, then nine bits and stop on the device clock
task automatic host_send(input logic [7:0] data, input logic parity, input logic stop,
	output bit ack);
	logic [9:0] bits;
	bit seen;
	int i;
	bits = {stop, parity, data};
	ack = 1'b0;
	@(posedge clk);
	host_clock <= 1'b0;
	repeat (ps2_pkg::INHIBIT_CYCLES + 8) @(posedge clk);
	host_data <= 1'b0;
	repeat (4) @(posedge clk);
	host_clock <= 1'b1;
	for (i = 0; i < 10; i++)
	begin
		// A busy device never starts clocking
		host_wait_clock(1'b0, i != 0, "device clock low", seen);
		if (!seen)
		begin
			host_data <= 1'b1;
			return;
		end
		host_data <= bits[i];
		host_wait_clock(1'b1, 1'b1, "device clock high", seen);
		if (!seen)
		begin
			host_data <= 1'b1;
			return;
		end
	end
	host_data <= 1'b1;
	// Bad frames get no eleventh pulse
	host_wait_clock(1'b0, 1'b0, "acknowledge pulse", seen);
	if (!seen)
		return;
	host_wait_clock(1'b1, 1'b1, "end of acknowledge pulse", seen);
	ack = seen && (ps2_data === 1'b0);
	repeat (2 * ps2_pkg::HALF_BIT_CYCLES) @(posedge clk);
endtask

task automatic host_receive(output logic [10:0] frame);
	bit seen;
	int i;
	frame = '1;
	for (i = 0; i < 11; i++)
	begin
		host_wait_clock(1'b0, 1'b1, "device clock falling edge", seen);
		if (!seen)
			return;
		frame[i] = ps2_data;
		host_wait_clock(1'b1, 1'b1, "device clock rising edge", seen);
		if (!seen)
			return;
	end
endtask

// Lets some bits pass, then holds the clock low during a high phase
task automatic host_inhibit(input int bits_before, input int hold_cycles);
	bit seen;
	int i;
	for (i = 0; i < bits_before; i++)
	begin
		host_wait_clock(1'b0, 1'b1, "device clock before inhibit", seen);
		host_wait_clock(1'b1, 1'b1, "device clock high before inhibit", seen);
	end
	host_clock <= 1'b0;
	repeat (hold_cycles) @(posedge clk);
	host_clock <= 1'b1;
endtask

//////////////////////////////
// Checks
//////////////////////////////

task automatic compare_byte(input string test, input logic [7:0] expected,
	input logic [7:0] actual);
	if (actual !== expected)
	begin
		$display("[ERROR] %s: expected 8'h%02h, actual 8'h%02h", test, expected, actual);
		error_count++;
	end
endtask

task automatic compare_bit(input string test, input logic expected, input logic actual);
	if (actual !== expected)
	begin
		$display("[ERROR] %s: expected %b, actual %b", test, expected, actual);
		error_count++;
	end
endtask

task automatic compare_state(input string test, input ps2_pkg::ps2_state_t expected,
	input ps2_pkg::ps2_state_t actual);
	if (actual !== expected)
	begin
		$display("[ERROR] %s: expected %s, actual %s", test, expected.name(), actual.name());
		error_count++;
	end
endtask

`endif

//--- tb/tb_ps2_device.sv
`timescale 1ns/1ps

module tb_ps2_device;
	import ps2_pkg::*;

	logic clk = 1'b0;
	logic reset;
	logic host_clock;
	logic host_data;
	logic ps2_clock;
	logic ps2_data;
	logic rx_ready;
	logic [7:0] tx_data;
	logic tx_valid;
	logic ps2_clock_oe;
	logic ps2_data_oe;
	logic [7:0] rx_data;
	logic rx_valid;
	logic tx_ready;
	logic cmd_error;

	int error_count = 0;
	int tx_ready_count = 0;
	int cmd_error_count = 0;
	int rx_valid_cycles = 0;
	int seed = 32'h5b0c_a05d;

	always #20 clk = ~clk;

	// Open-drain lines where either side can pull low
	assign ps2_clock = host_clock & ~ps2_clock_oe;
	assign ps2_data = host_data & ~ps2_data_oe;

	ps2_device i_ps2_device (
		.clk          (clk),
		.reset        (reset),
		.ps2_clock_in (ps2_clock),
		.ps2_data_in  (ps2_data),
		.rx_ready     (rx_ready),
		.tx_data      (tx_data),
		.tx_valid     (tx_valid),
		.ps2_clock_oe (ps2_clock_oe),
		.ps2_data_oe  (ps2_data_oe),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.tx_ready     (tx_ready),
		.cmd_error    (cmd_error)
	);

	// Pulse counters for the user side
	always @(posedge clk)
	begin
		if (tx_ready)
			tx_ready_count++;
		if (cmd_error)
			cmd_error_count++;
		if (rx_valid)
			rx_valid_cycles++;
	end

	`include "ps2_host_tasks.svh"

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Parity bit that makes the nine bits odd
	function automatic logic odd_parity(input logic [7:0] data);
		int ones;
		int i;
		ones = 0;
		for (i = 0; i < 8; i++)
			ones = ones + (data[i] ? 1 : 0);
		return (ones % 2 == 0);
	endfunction

	function automatic logic [7:0] random_byte();
		logic [31:0] value;
		value = $random(seed);
		return value[7:0];
	endfunction

	task automatic wait_rx_valid(input string test);
		int count;
		count = 0;
		while (rx_valid !== 1'b1 && count < HOST_TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			count++;
		end
		if (rx_valid !== 1'b1)
		begin
			$display("%s: rx_valid never rose", test);
			error_count++;
		end
	endtask

	task automatic wait_tx_ready(input string test, input int start);
		int count;
		count = 0;
		while (tx_ready_count == start && count < HOST_TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			count++;
		end
		if (tx_ready_count == start)
		begin
			$display("%s: tx_ready never pulsed", test);
			error_count++;
		end
	endtask

	task automatic rx_handshake(input string test);
		@(posedge clk);
		rx_ready <= 1'b1;
		@(posedge clk);
		rx_ready <= 1'b0;
		@(negedge clk);
		compare_bit({test, " rx_valid after handshake"}, 1'b0, rx_valid);
	endtask

	task automatic check_quiet(input string test);
		compare_bit({test, " ps2_clock_oe"}, 1'b0, ps2_clock_oe);
		compare_bit({test, " ps2_data_oe"}, 1'b0, ps2_data_oe);
		compare_bit({test, " rx_valid"}, 1'b0, rx_valid);
		compare_bit({test, " tx_ready"}, 1'b0, tx_ready);
		compare_bit({test, " cmd_error"}, 1'b0, cmd_error);
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic reset_test();
		int i;
		for (i = 0; i < 5; i++)
		begin
			@(negedge clk);
			check_quiet("reset held");
		end
		@(posedge clk);
		reset <= 1'b1;
		for (i = 0; i < 4; i++)
		begin
			@(negedge clk);
			check_quiet("after reset");
		end
		compare_state("after reset", ST_IDLE, i_ps2_device.i_device_fsm.state);
	endtask

	task automatic receive_test();
		logic [7:0] data;
		bit ack;
		int i;
		for (i = 0; i < 4; i++)
		begin
			data = random_byte();
			host_send(data, odd_parity(data), 1'b1, ack);
			compare_bit("receive ack", 1'b1, ack);
			wait_rx_valid("receive");
			compare_byte("receive data", data, rx_data);
			rx_handshake("receive");
		end
	endtask

	// Optionally inhibits after three bits, then expects the whole frame again
	task automatic transmit_check(input string test, input logic [7:0] data, input bit inhibit);
		logic [10:0] frame;
		int start;
		start = tx_ready_count;
		@(posedge clk);
		tx_data <= data;
		tx_valid <= 1'b1;
		if (inhibit)
		begin
			host_inhibit(3, 200);
			@(negedge clk);
			compare_byte({test, " tx_ready while inhibited"}, 8'd0,
				8'(tx_ready_count - start));
			compare_state({test, " after abort"}, ST_IDLE, i_ps2_device.i_device_fsm.state);
		end
		host_receive(frame);
		compare_bit({test, " start"}, 1'b0, frame[0]);
		compare_byte({test, " data"}, data, frame[8:1]);
		compare_bit({test, " parity"}, odd_parity(data), frame[9]);
		compare_bit({test, " stop"}, 1'b1, frame[10]);
		wait_tx_ready(test, start);
		@(posedge clk);
		tx_valid <= 1'b0;
		repeat (60) @(posedge clk);
		@(negedge clk);
		compare_byte({test, " tx_ready pulses"}, 8'd1, 8'(tx_ready_count - start));
	endtask

	task automatic transmit_test();
		int i;
		for (i = 0; i < 4; i++)
			transmit_check("transmit", random_byte(), 1'b0);
	endtask

	task automatic bad_frame_test(input string test, input bit bad_stop);
		logic [7:0] data;
		logic parity;
		bit ack;
		int error_start;
		int valid_start;
		data = random_byte();
		parity = bad_stop ? odd_parity(data) : !odd_parity(data);
		error_start = cmd_error_count;
		valid_start = rx_valid_cycles;
		host_send(data, parity, !bad_stop, ack);
		repeat (20) @(posedge clk);
		@(negedge clk);
		compare_bit({test, " ack"}, 1'b0, ack);
		compare_byte({test, " cmd_error pulses"}, 8'd1, 8'(cmd_error_count - error_start));
		compare_byte({test, " rx_valid cycles"}, 8'd0, 8'(rx_valid_cycles - valid_start));
		compare_state({test, " state"}, ST_IDLE, i_ps2_device.i_device_fsm.state);
	endtask

	task automatic backpressure_test();
		logic [7:0] first;
		logic [7:0] second;
		bit ack;
		first = random_byte();
		second = random_byte();
		host_send(first, odd_parity(first), 1'b1, ack);
		compare_bit("backpressure first ack", 1'b1, ack);
		wait_rx_valid("backpressure first");
		// Device holds the byte, so this request sees no clock
		host_send(second, odd_parity(second), 1'b1, ack);
		@(negedge clk);
		compare_bit("backpressure blocked ack", 1'b0, ack);
		compare_bit("backpressure rx_valid held", 1'b1, rx_valid);
		compare_byte("backpressure rx_data held", first, rx_data);
		compare_state("backpressure state", ST_RX_HOLD, i_ps2_device.i_device_fsm.state);
		rx_handshake("backpressure first");
		host_send(second, odd_parity(second), 1'b1, ack);
		compare_bit("backpressure retry ack", 1'b1, ack);
		wait_rx_valid("backpressure retry");
		compare_byte("backpressure retry data", second, rx_data);
		rx_handshake("backpressure retry");
	endtask

	initial
	begin
		reset <= 1'b0;
		host_clock <= 1'b1;
		host_data <= 1'b1;
		rx_ready <= 1'b0;
		tx_data <= 8'h00;
		tx_valid <= 1'b0;
		reset_test();
		receive_test();
		transmit_test();
		bad_frame_test("bad parity", 1'b0);
		bad_frame_test("bad stop", 1'b1);
		backpressure_test();
		transmit_check("inhibit abort", random_byte(), 1'b1);
		$display("Simulation done with %0d errors", error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- logic/ps2_device.sv
`timescale 1ns/1ps

module ps2_device (
	input  logic clk,
	input  logic reset,
	input  logic ps2_clock_in,
	input  logic ps2_data_in,
	input  logic rx_ready,
	input  logic [7:0] tx_data,
	input  logic tx_valid,
	output logic ps2_clock_oe,
	output logic ps2_data_oe,
	output logic [7:0] rx_data,
	output logic rx_valid,
	output logic tx_ready,
	output logic cmd_error
);
	import ps2_pkg::*;

	logic tick_run;
	logic half_tick;
	logic clock_held_low;
	logic clock_held_high;
	shift_op_t shift_op;
	logic out_bit;
	logic frame_done;
	logic frame_ok;

	ps2_line_timer i_line_timer (
		.clk             (clk),
		.reset           (reset),
		.ps2_clock_in    (ps2_clock_in),
		.tick_run        (tick_run),
		.half_tick       (half_tick),
		.clock_held_low  (clock_held_low),
		.clock_held_high (clock_held_high)
	);

	// Received bits come straight off the data line
	ps2_frame_shifter i_frame_shifter (
		.clk        (clk),
		.reset      (reset),
		.shift_op   (shift_op),
		.tx_byte    (tx_data),
		.sample_bit (ps2_data_in),
		.out_bit    (out_bit),
		.frame_done (frame_done),
		.frame_ok   (frame_ok),
		.rx_byte    (rx_data)
	);

	ps2_device_fsm i_device_fsm (
		.clk             (clk),
		.reset           (reset),
		.ps2_clock_in    (ps2_clock_in),
		.ps2_data_in     (ps2_data_in),
		.half_tick       (half_tick),
		.clock_held_low  (clock_held_low),
		.clock_held_high (clock_held_high),
		.frame_done      (frame_done),
		.frame_ok        (frame_ok),
		.out_bit         (out_bit),
		.tx_valid        (tx_valid),
		.rx_ready        (rx_ready),
		.tick_run        (tick_run),
		.shift_op        (shift_op),
		.ps2_clock_oe    (ps2_clock_oe),
		.ps2_data_oe     (ps2_data_oe),
		.rx_valid        (rx_valid),
		.tx_ready        (tx_ready),
		.cmd_error       (cmd_error)
	);

endmodule

//--- logic/ps2_device_fsm.sv
`timescale 1ns/1ps

module ps2_device_fsm (
	input  logic clk,
	input  logic reset,
	input  logic ps2_clock_in,
	input  logic ps2_data_in,
	input  logic half_tick,
	input  logic clock_held_low,
	input  logic clock_held_high,
	input  logic frame_done,
	input  logic frame_ok,
	input  logic out_bit,
	input  logic tx_valid,
	input  logic rx_ready,
	output logic tick_run,
	output ps2_pkg::shift_op_t shift_op,
	output logic ps2_clock_oe,
	output logic ps2_data_oe,
	output logic rx_valid,
	output logic tx_ready,
	output logic cmd_error
);
	import ps2_pkg::*;

	ps2_state_t state;
	ps2_state_t state_next;
	logic rts_seen;
	logic frame_bad;
	logic tx_finish;

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb
	begin
		state_next = state;
		shift_op = OP_HOLD;
		case (state)
			ST_IDLE:
			begin
				// Host request wins over a waiting byte
				if (rts_seen && ps2_clock_in)
				begin
					state_next = ST_RX_LOW;
					shift_op = OP_CLEAR;
				end
				else if (tx_valid && clock_held_high)
				begin
					state_next = ST_TX_HIGH;
					shift_op = OP_LOAD_TX;
				end
			end
			ST_RX_LOW:
			begin
				// Sample as our clock rises
				if (half_tick)
				begin
					state_next = ST_RX_HIGH;
					shift_op = OP_SAMPLE;
				end
			end
			ST_RX_HIGH:
			begin
				if (half_tick && frame_done)
					state_next = frame_ok ? ST_ACK_LOW : ST_IDLE;
				else if (half_tick)
					state_next = ST_RX_LOW;
			end
			ST_ACK_LOW:
				if (half_tick)
					state_next = ST_ACK_HIGH;
			ST_ACK_HIGH:
				if (half_tick)
					state_next = ST_RX_HOLD;
			ST_RX_HOLD:
				if (rx_ready)
					state_next = ST_IDLE;
			ST_TX_HIGH:
			begin
				// Line low without us pulling it means host inhibit
				if (frame_done)
					state_next = ST_TX_END;
				else if (!ps2_clock_in)
					state_next = ST_IDLE;
				else if (half_tick)
					state_next = ST_TX_LOW;
			end
			ST_TX_LOW:
			begin
				if (half_tick)
				begin
					state_next = ST_TX_HIGH;
					shift_op = OP_ADVANCE;
				end
			end
			ST_TX_END:
				if (half_tick)
					state_next = ST_IDLE;
			default:
				state_next = ST_IDLE;
		endcase
	end

	assign frame_bad = (state == ST_RX_HIGH) && half_tick && frame_done && !frame_ok;
	assign tx_finish = (state == ST_TX_END) && half_tick;

	//////////////////////////////
	// Registers
	//////////////////////////////

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state <= ST_IDLE;
			rts_seen <= 1'b0;
			rx_valid <= 1'b0;
			tx_ready <= 1'b0;
			cmd_error <= 1'b0;
		end
		else
		begin
			state <= state_next;
			// Cleared as soon as the host lets data go
			rts_seen <= (state_next == ST_IDLE) && !ps2_data_in &&
				(rts_seen || clock_held_low);
			rx_valid <= (state_next == ST_RX_HOLD);
			tx_ready <= tx_finish;
			cmd_error <= frame_bad;
		end
	end

	//////////////////////////////
	// Bus drive
	//////////////////////////////

	assign tick_run = state inside {ST_RX_LOW, ST_RX_HIGH, ST_ACK_LOW, ST_ACK_HIGH,
		ST_TX_HIGH, ST_TX_LOW, ST_TX_END};

	assign ps2_clock_oe = state inside {ST_RX_LOW, ST_ACK_LOW, ST_TX_LOW};

	// out_bit is zero throughout the acknowledge
	assign ps2_data_oe = !out_bit &&
		(state inside {ST_TX_HIGH, ST_TX_LOW, ST_ACK_LOW, ST_ACK_HIGH});

endmodule

//--- logic/ps2_frame_shifter.sv
`timescale 1ns/1ps

module ps2_frame_shifter (
	input  logic clk,
	input  logic reset,
	input  ps2_pkg::shift_op_t shift_op,
	input  logic [7:0] tx_byte,
	input  logic sample_bit,
	output logic out_bit,
	output logic frame_done,
	output logic frame_ok,
	output logic [7:0] rx_byte
);
	import ps2_pkg::*;

	// Bit 0 is the next bit on the wire
	logic [10:0] tx_frame;
	// Fills from the top, d0 ends up in bit 0
	logic [9:0] rx_frame;
	logic [3:0] bit_count;
	logic tx_mode;

	//////////////////////////////
	// Bit counter and direction
	//////////////////////////////

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			bit_count <= '0;
			tx_mode <= 1'b0;
		end
		else
		begin
			case (shift_op)
				OP_LOAD_TX:
				begin
					bit_count <= '0;
					tx_mode <= 1'b1;
				end
				OP_CLEAR:
				begin
					bit_count <= '0;
					tx_mode <= 1'b0;
				end
				OP_SAMPLE, OP_ADVANCE:
					bit_count <= bit_count + 1'b1;
				default:
					bit_count <= bit_count;
			endcase
		end
	end

	//////////////////////////////
	// Frame data
	//////////////////////////////

	// Start, data LSB first, odd parity, stop
	always_ff @(posedge clk)
	begin
		case (shift_op)
			OP_LOAD_TX:
				tx_frame <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
			// Zero on the line for the acknowledge
			OP_CLEAR:
				tx_frame <= '0;
			OP_ADVANCE:
				tx_frame <= {1'b1, tx_frame[10:1]};
			default:
				tx_frame <= tx_frame;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (shift_op == OP_SAMPLE)
			rx_frame <= {sample_bit, rx_frame[9:1]};
	end

	assign out_bit = tx_frame[0];
	assign frame_done = (bit_count == (tx_mode ? TX_FRAME_BITS : RX_FRAME_BITS));

	// Nine bits odd and stop high
	assign frame_ok = rx_frame[9] && (^rx_frame[8:0]);
	assign rx_byte = rx_frame[7:0];

endmodule

//--- logic/ps2_line_timer.sv
`timescale 1ns/1ps

module ps2_line_timer (
	input  logic clk,
	input  logic reset,
	input  logic ps2_clock_in,
	input  logic tick_run,
	output logic half_tick,
	output logic clock_held_low,
	output logic clock_held_high
);
	import ps2_pkg::*;

	logic clock_prev;
	logic [LEVEL_COUNT_W-1:0] level_count;
	logic [LEVEL_COUNT_W-1:0] tick_count;

	//////////////////////////////
	// Clock line level duration
	//////////////////////////////

	// Restarts on every edge of the line, sticks at all ones
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			clock_prev <= 1'b1;
			level_count <= '0;
		end
		else
		begin
			clock_prev <= ps2_clock_in;
			if (ps2_clock_in != clock_prev)
				level_count <= '0;
			else if (level_count != '1)
				level_count <= level_count + 1'b1;
		end
	end

	assign clock_held_low = !clock_prev &&
		(level_count >= LEVEL_COUNT_W'(INHIBIT_CYCLES - 1));

	assign clock_held_high = clock_prev &&
		(level_count >= LEVEL_COUNT_W'(IDLE_CYCLES - 1));

	//////////////////////////////
	// Half-bit divider
	//////////////////////////////

	// Held at zero while idle so the first phase is full length
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			tick_count <= '0;
		else if (!tick_run || half_tick)
			tick_count <= '0;
		else
			tick_count <= tick_count + 1'b1;
	end

	// Last cycle of the current phase
	assign half_tick = tick_run &&
		(tick_count == LEVEL_COUNT_W'(HALF_BIT_CYCLES - 1));

endmodule

//--- logic/ps2_pkg.sv
package ps2_pkg;

	//////////////////////////////
	// Bus timing in clk cycles
	//////////////////////////////

	// One phase of the clock the device generates
	localparam logic [31:0] HALF_BIT_CYCLES = 32'd8;

	// Clock low this long, then data low, means request-to-send
	localparam logic [31:0] INHIBIT_CYCLES = 32'd40;

	// Clock high this long before a transmit may start
	localparam logic [31:0] IDLE_CYCLES = 32'd48;

	localparam int unsigned LEVEL_COUNT_W = 7;

	// Bits per frame as seen by the shifter
	localparam logic [3:0] TX_FRAME_BITS = 4'd11;
	localparam logic [3:0] RX_FRAME_BITS = 4'd10;

	// Host model wait limit
	localparam int HOST_TIMEOUT_CYCLES = 2000;

	//////////////////////////////
	// Shared types
	//////////////////////////////

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_RX_LOW,
		ST_RX_HIGH,
		ST_ACK_LOW,
		ST_ACK_HIGH,
		ST_RX_HOLD,
		ST_TX_HIGH,
		ST_TX_LOW,
		ST_TX_END
	} ps2_state_t;

	typedef enum logic [2:0] {
		OP_HOLD,
		OP_LOAD_TX,
		OP_CLEAR,
		OP_SAMPLE,
		OP_ADVANCE
	} shift_op_t;

endpackage
